// ==== logic/noc_config.svh ====
// Mesh size, flit width and buffer depth for the NoC
// Credit counters start at the buffer depth

`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Grid dimensions
`define NOC_ROWS 2
`define NOC_COLS 2

// Payload bits per flit
`define NOC_FLIT_WIDTH 32

// Flits per input FIFO
`define NOC_BUFFER_DEPTH 4

`endif

// ==== logic/noc_pkg.sv ====
// Shared NoC types: flit struct, port enumeration, derived widths

`include "noc_config.svh"

package noc_pkg;

    localparam int noc_nodes = `NOC_ROWS * `NOC_COLS;
    localparam int dest_width = $clog2(noc_nodes);

    // Counts 0 up to the buffer depth inclusive
    localparam int credit_width = $clog2(`NOC_BUFFER_DEPTH + 1);

    localparam int num_ports = 5;
    localparam int port_width = 3;

    // Node index is row * cols + col, row 0 on the north edge
    typedef logic [dest_width-1:0] node_t;

    typedef struct packed {
        logic [`NOC_FLIT_WIDTH-1:0] data;
        node_t                      dest;
        logic                       is_tail;
    } flit_t;

    typedef enum logic [port_width-1:0] {
        PORT_LOCAL = 3'd0,
        PORT_NORTH = 3'd1,
        PORT_SOUTH = 3'd2,
        PORT_EAST  = 3'd3,
        PORT_WEST  = 3'd4
    } port_e;

endpackage

// ==== logic/noc_link_if.sv ====
// One direction of a router link
// Flit and send travel forward, credit pulses travel back

interface noc_link_if import noc_pkg::*; ();

    flit_t flit;
    logic  send;
    logic  credit;

    modport sender (
        output flit,
        output send,
        input  credit
    );

    modport receiver (
        input  flit,
        input  send,
        output credit
    );

endinterface

// ==== logic/flit_fifo.sv ====
// Router input buffer for flits
// Returns one credit pulse per flit removed

`include "noc_config.svh"

module flit_fifo import noc_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    noc_link_if.receiver in,
    output flit_t        head,
    output logic         valid,
    input  logic         pop
);

    localparam int ptr_width = $clog2(`NOC_BUFFER_DEPTH);

    flit_t                   mem [`NOC_BUFFER_DEPTH];
    logic [ptr_width-1:0]    wr_ptr;
    logic [ptr_width-1:0]    rd_ptr;
    logic [credit_width-1:0] count;
    logic                    credit_q;

    function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
        logic [ptr_width-1:0] next;
        if (ptr == ptr_width'(`NOC_BUFFER_DEPTH - 1)) begin
            next = '0;
        end else begin
            next = ptr + 1'b1;
        end
        return next;
    endfunction

    always_ff @(posedge clk) begin
        if (in.send) begin
            mem[wr_ptr] <= in.flit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (in.send) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({in.send, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Slot freed at this edge, tell the sender next cycle
            credit_q <= pop;
        end
    end

    assign head      = mem[rd_ptr];
    assign valid     = (count != '0);
    assign in.credit = credit_q;

    // Upstream credit counter must never overrun this buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in.send |-> count < credit_width'(`NOC_BUFFER_DEPTH))
        else $error("flit_fifo: write while full, credit protocol broken");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> valid)
        else $error("flit_fifo: pop while empty");

endmodule

// ==== logic/output_port.sv ====
// One router output with round-robin arbiter and wormhole lock,
// credit counter for the downstream buffer and registered link outputs

`include "noc_config.svh"

module output_port import noc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  flit_t                heads [num_ports],
    input  logic [num_ports-1:0] requests,
    output logic [num_ports-1:0] grants,
    noc_link_if.sender           out
);

    logic [credit_width-1:0] credits;
    logic                    locked;
    logic [port_width-1:0]   lock_owner;
    logic [port_width-1:0]   last_grant;
    logic [port_width-1:0]   sel;
    logic                    grant_any;
    flit_t                   flit_q;
    logic                    send_q;

    // Grant is combinational so the FIFO pops on the same edge
    always_comb begin
        int idx;
        grants = '0;
        sel    = '0;
        idx    = 0;
        if (credits != '0) begin
            if (locked) begin
                // Body flits of the open packet only
                if (requests[lock_owner]) begin
                    grants[lock_owner] = 1'b1;
                    sel                = lock_owner;
                end
            end else begin
                for (int k = 1; k <= num_ports; k++) begin
                    idx = (int'(last_grant) + k) % num_ports;
                    if (requests[idx] && grants == '0) begin
                        grants[idx] = 1'b1;
                        sel         = port_width'(idx);
                    end
                end
            end
        end
    end

    assign grant_any = |grants;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits    <= credit_width'(`NOC_BUFFER_DEPTH);
            locked     <= 1'b0;
            lock_owner <= '0;
            last_grant <= port_width'(num_ports - 1);
            send_q     <= 1'b0;
        end else begin
            case ({grant_any, out.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (grant_any) begin
                last_grant <= sel;
                lock_owner <= sel;
                // Hold the output until the tail has gone
                locked     <= !heads[sel].is_tail;
            end
            send_q <= grant_any;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_any) begin
            flit_q <= heads[sel];
        end
    end

    assign out.flit = flit_q;
    assign out.send = send_q;

    // Downstream returns at most one credit per flit it was sent
    a_credit_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        out.credit |-> credits != credit_width'(`NOC_BUFFER_DEPTH))
        else $error("output_port: credit returned with the counter already full");

endmodule

// ==== logic/mesh_router.sv ====
// Five-port mesh router with XY route compute,
// an input FIFO per port and an output port per direction

`include "noc_config.svh"

module mesh_router import noc_pkg::*; #(
    parameter int row    = 0,
    parameter int column = 0
) (
    input  logic         clk,
    input  logic         rst_n,
    noc_link_if.receiver link_in  [num_ports],
    noc_link_if.sender   link_out [num_ports]
);

    flit_t                heads [num_ports];
    logic [num_ports-1:0] valid;
    port_e                route [num_ports];
    logic [num_ports-1:0] req   [num_ports];
    logic [num_ports-1:0] grant [num_ports];
    logic [num_ports-1:0] pop;

    // Columns first, then rows; row index grows to the south
    function automatic port_e xy_route(input node_t dest);
        int    dest_row;
        int    dest_col;
        port_e dir;
        dest_row = int'(dest) / `NOC_COLS;
        dest_col = int'(dest) % `NOC_COLS;
        if (dest_col > column) begin
            dir = PORT_EAST;
        end else if (dest_col < column) begin
            dir = PORT_WEST;
        end else if (dest_row > row) begin
            dir = PORT_SOUTH;
        end else if (dest_row < row) begin
            dir = PORT_NORTH;
        end else begin
            dir = PORT_LOCAL;
        end
        return dir;
    endfunction

    for (genvar i = 0; i < num_ports; i++) begin : g_in
        flit_fifo u_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .in    (link_in[i]),
            .head  (heads[i]),
            .valid (valid[i]),
            .pop   (pop[i])
        );

        assign route[i] = xy_route(heads[i].dest);
    end

    // req[o][i]: input i has a head flit bound for output o
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            for (int i = 0; i < num_ports; i++) begin
                req[o][i] = valid[i] && (route[i] == port_e'(o));
            end
        end
    end

    for (genvar o = 0; o < num_ports; o++) begin : g_out
        output_port u_port (
            .clk      (clk),
            .rst_n    (rst_n),
            .heads    (heads),
            .requests (req[o]),
            .grants   (grant[o]),
            .out      (link_out[o])
        );
    end

    // Each input routes to one output, so at most one grant per input
    always_comb begin
        pop = '0;
        for (int o = 0; o < num_ports; o++) begin
            pop = pop | grant[o];
        end
    end

endmodule

// ==== logic/mesh.sv ====
// 2x2 mesh NoC top level: routers, neighbour links,
// edge tie-offs and per-node endpoint ports

`include "noc_config.svh"

module mesh import noc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic [`NOC_FLIT_WIDTH-1:0] data_in     [noc_nodes],
    input  node_t                      dest_in     [noc_nodes],
    input  logic                       is_tail_in  [noc_nodes],
    input  logic                       send_in     [noc_nodes],
    output logic                       credit_out  [noc_nodes],

    output logic [`NOC_FLIT_WIDTH-1:0] data_out    [noc_nodes],
    output node_t                      dest_out    [noc_nodes],
    output logic                       is_tail_out [noc_nodes],
    output logic                       send_out    [noc_nodes],
    input  logic                       credit_in   [noc_nodes]
);

    // Router side of every link, by node and port
    flit_t in_flit    [noc_nodes][num_ports];
    logic  in_send    [noc_nodes][num_ports];
    logic  in_credit  [noc_nodes][num_ports];
    flit_t out_flit   [noc_nodes][num_ports];
    logic  out_send   [noc_nodes][num_ports];
    logic  out_credit [noc_nodes][num_ports];

    // Forward direction; missing neighbours leave the input idle
    always_comb begin
        for (int n = 0; n < noc_nodes; n++) begin
            for (int p = 0; p < num_ports; p++) begin
                in_flit[n][p] = '0;
                in_send[n][p] = 1'b0;
            end
            in_flit[n][PORT_LOCAL] = '{data: data_in[n], dest: dest_in[n], is_tail: is_tail_in[n]};
            in_send[n][PORT_LOCAL] = send_in[n];
            if (n >= `NOC_COLS) begin
                in_flit[n][PORT_NORTH] = out_flit[n - `NOC_COLS][PORT_SOUTH];
                in_send[n][PORT_NORTH] = out_send[n - `NOC_COLS][PORT_SOUTH];
            end
            if (n < noc_nodes - `NOC_COLS) begin
                in_flit[n][PORT_SOUTH] = out_flit[n + `NOC_COLS][PORT_NORTH];
                in_send[n][PORT_SOUTH] = out_send[n + `NOC_COLS][PORT_NORTH];
            end
            if (n % `NOC_COLS != `NOC_COLS - 1) begin
                in_flit[n][PORT_EAST] = out_flit[n + 1][PORT_WEST];
                in_send[n][PORT_EAST] = out_send[n + 1][PORT_WEST];
            end
            if (n % `NOC_COLS != 0) begin
                in_flit[n][PORT_WEST] = out_flit[n - 1][PORT_EAST];
                in_send[n][PORT_WEST] = out_send[n - 1][PORT_EAST];
            end
        end
    end

    // Credits flow back from the neighbour's matching input FIFO
    always_comb begin
        for (int n = 0; n < noc_nodes; n++) begin
            for (int p = 0; p < num_ports; p++) begin
                out_credit[n][p] = 1'b0;
            end
            out_credit[n][PORT_LOCAL] = credit_in[n];
            if (n >= `NOC_COLS) begin
                out_credit[n][PORT_NORTH] = in_credit[n - `NOC_COLS][PORT_SOUTH];
            end
            if (n < noc_nodes - `NOC_COLS) begin
                out_credit[n][PORT_SOUTH] = in_credit[n + `NOC_COLS][PORT_NORTH];
            end
            if (n % `NOC_COLS != `NOC_COLS - 1) begin
                out_credit[n][PORT_EAST] = in_credit[n + 1][PORT_WEST];
            end
            if (n % `NOC_COLS != 0) begin
                out_credit[n][PORT_WEST] = in_credit[n - 1][PORT_EAST];
            end
        end
    end

    for (genvar n = 0; n < noc_nodes; n++) begin : g_node
        noc_link_if link_in  [num_ports] ();
        noc_link_if link_out [num_ports] ();

        for (genvar p = 0; p < num_ports; p++) begin : g_port
            assign link_in[p].flit    = in_flit[n][p];
            assign link_in[p].send    = in_send[n][p];
            assign in_credit[n][p]    = link_in[p].credit;
            assign out_flit[n][p]     = link_out[p].flit;
            assign out_send[n][p]     = link_out[p].send;
            assign link_out[p].credit = out_credit[n][p];
        end

        mesh_router #(
            .row    (n / `NOC_COLS),
            .column (n % `NOC_COLS)
        ) u_router (
            .clk      (clk),
            .rst_n    (rst_n),
            .link_in  (link_in),
            .link_out (link_out)
        );

        // Ejection side of the endpoint
        assign data_out[n]    = out_flit[n][PORT_LOCAL].data;
        assign dest_out[n]    = out_flit[n][PORT_LOCAL].dest;
        assign is_tail_out[n] = out_flit[n][PORT_LOCAL].is_tail;
        assign send_out[n]    = out_send[n][PORT_LOCAL];
        assign credit_out[n]  = in_credit[n][PORT_LOCAL];
    end

endmodule

// ==== tests/tb_mesh.sv ====
// Testbench for the 2x2 mesh NoC
// Credit-tracking endpoints, reference data model, per-pair scoreboard, watchdog

`include "noc_config.svh"

module tb_mesh import noc_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int depth          = `NOC_BUFFER_DEPTH;
    localparam int pairs          = noc_nodes * noc_nodes;
    localparam int random_packets = 200;
    localparam int bp_node        = noc_nodes - 1;
    localparam int bp_packets     = 2 * (noc_nodes - 1);
    localparam int total_packets  = noc_nodes * (noc_nodes - 1) + noc_nodes
                                    + random_packets + bp_packets;
    localparam int timeout_ns     = total_packets * 4 * 40 + 5000;

    logic                       clk   = 1'b0;
    logic                       rst_n = 1'b0;
    logic [`NOC_FLIT_WIDTH-1:0] data_in     [noc_nodes] = '{default: '0};
    node_t                      dest_in     [noc_nodes] = '{default: '0};
    logic                       is_tail_in  [noc_nodes] = '{default: 1'b0};
    logic                       send_in     [noc_nodes] = '{default: 1'b0};
    logic                       credit_out  [noc_nodes];
    logic [`NOC_FLIT_WIDTH-1:0] data_out    [noc_nodes];
    node_t                      dest_out    [noc_nodes];
    logic                       is_tail_out [noc_nodes];
    logic                       send_out    [noc_nodes];
    logic                       credit_in   [noc_nodes] = '{default: 1'b0};

    // Injection queues per source, expected flits per source-destination pair
    flit_t tx_q  [noc_nodes][$];
    flit_t exp_q [pairs][$];

    int seq_num        [pairs]     = '{default: 0};
    int src_credits    [noc_nodes] = '{default: depth};
    int injected       [noc_nodes] = '{default: 0};
    int credit_pulses  [noc_nodes] = '{default: 0};
    int pending_credit [noc_nodes] = '{default: 0};
    int held_ejects    [noc_nodes] = '{default: 0};
    int open_src       [noc_nodes] = '{default: -1};
    bit hold           [noc_nodes] = '{default: 1'b0};
    int mismatch_count = 0;
    int other_count    = 0;

    always #5 clk = ~clk;

    mesh u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_in     (data_in),
        .dest_in     (dest_in),
        .is_tail_in  (is_tail_in),
        .send_in     (send_in),
        .credit_out  (credit_out),
        .data_out    (data_out),
        .dest_out    (dest_out),
        .is_tail_out (is_tail_out),
        .send_out    (send_out),
        .credit_in   (credit_in)
    );

    // Data word built from source, destination, packet number and flit position
    function automatic logic [`NOC_FLIT_WIDTH-1:0] expected_word(input int src, input int dst,
                                                                 input int seq, input int pos);
        return {4'(src), 4'(dst), 16'(seq), 8'(pos)};
    endfunction

    task automatic make_packet(input int src, input int dst, input int len);
        flit_t f;
        int    pair;
        pair = src * noc_nodes + dst;
        for (int pos = 0; pos < len; pos++) begin
            f.data    = expected_word(src, dst, seq_num[pair], pos);
            f.dest    = node_t'(dst);
            f.is_tail = (pos == len - 1);
            tx_q[src].push_back(f);
            exp_q[pair].push_back(f);
        end
        seq_num[pair]++;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("CHECK FAILED at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic receive_flit(input int n);
        int    src;
        flit_t exp;
        src = int'(data_out[n][`NOC_FLIT_WIDTH-1 -: 4]);
        pending_credit[n]++;
        if (hold[n]) begin
            held_ejects[n]++;
        end
        if (src >= noc_nodes || exp_q[src * noc_nodes + n].size() == 0) begin
            other_count++;
            $display("ERROR at time %0t: node %0d ejected an unexpected flit with data %0h",
                     $time, n, data_out[n]);
        end else begin
            exp = exp_q[src * noc_nodes + n].pop_front();
            check_value($sformatf("data_out[%0d]", n), 64'(data_out[n]), 64'(exp.data));
            check_value($sformatf("dest_out[%0d]", n), 64'(dest_out[n]), 64'(n));
            check_value($sformatf("is_tail_out[%0d]", n), 64'(is_tail_out[n]),
                        64'(exp.is_tail));
        end
        // Flits of another packet must not cut into an open one
        if (open_src[n] >= 0 && open_src[n] != src) begin
            other_count++;
            $display("ERROR at time %0t: at node %0d a flit from %0d cut into a packet from %0d",
                     $time, n, src, open_src[n]);
        end
        open_src[n] = is_tail_out[n] ? -1 : src;
    endtask

    // Source endpoints inject while their credit mirror is above zero
    always @(posedge clk) begin
        flit_t f;
        for (int n = 0; n < noc_nodes; n++) begin
            if (rst_n && credit_out[n]) begin
                src_credits[n]++;
                credit_pulses[n]++;
            end
            if (rst_n && src_credits[n] > 0 && tx_q[n].size() > 0) begin
                f = tx_q[n].pop_front();
                data_in[n]    <= f.data;
                dest_in[n]    <= f.dest;
                is_tail_in[n] <= f.is_tail;
                send_in[n]    <= 1'b1;
                src_credits[n]--;
                injected[n]++;
            end else begin
                send_in[n] <= 1'b0;
            end
        end
    end

    // Ejection endpoints compare every flit and return one credit per flit
    always @(posedge clk) begin
        for (int n = 0; n < noc_nodes; n++) begin
            if (rst_n && send_out[n]) begin
                receive_flit(n);
            end
            if (!hold[n] && pending_credit[n] > 0) begin
                credit_in[n] <= 1'b1;
                pending_credit[n]--;
            end else begin
                credit_in[n] <= 1'b0;
            end
        end
    end

    task automatic wait_drain();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int n = 0; n < noc_nodes; n++) begin
                if (tx_q[n].size() != 0 || pending_credit[n] != 0) begin
                    busy = 1'b1;
                end
            end
            for (int p = 0; p < pairs; p++) begin
                if (exp_q[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
        // Last credit pulses still on their way back
        repeat (4) @(negedge clk);
    endtask

    task automatic check_end_state();
        for (int n = 0; n < noc_nodes; n++) begin
            check_value($sformatf("credit_out[%0d] pulse count", n), 64'(credit_pulses[n]),
                        64'(injected[n]));
            check_value($sformatf("source credits at node %0d", n), 64'(src_credits[n]),
                        64'(depth));
        end
    endtask

    task automatic report_undelivered();
        for (int p = 0; p < pairs; p++) begin
            if (exp_q[p].size() != 0) begin
                other_count++;
                $display("ERROR: %0d flits from node %0d to node %0d were never delivered",
                         exp_q[p].size(), p / noc_nodes, p % noc_nodes);
            end
        end
    endtask

    initial begin
        #(timeout_ns);
        other_count++;
        $display("ERROR: watchdog expired after %0d ns with traffic still pending", timeout_ns);
        report_undelivered();
        $display("Errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int src;
        int dst;
        int len;
        void'($urandom(32'he001));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // One flit between every pair of distinct nodes
        for (int s = 0; s < noc_nodes; s++) begin
            for (int d = 0; d < noc_nodes; d++) begin
                if (s != d) begin
                    make_packet(s, d, 1);
                end
            end
        end
        wait_drain();

        for (int s = 0; s < noc_nodes; s++) begin
            make_packet(s, s, 3);
        end
        wait_drain();

        // Random all-to-all traffic
        for (int k = 0; k < random_packets; k++) begin
            src = $urandom_range(noc_nodes - 1, 0);
            dst = $urandom_range(noc_nodes - 1, 0);
            len = $urandom_range(4, 1);
            make_packet(src, dst, len);
        end
        wait_drain();

        // Endpoint withholds credit while all others send to it
        hold[bp_node] = 1'b1;
        for (int s = 0; s < noc_nodes; s++) begin
            if (s != bp_node) begin
                make_packet(s, bp_node, 3);
                make_packet(s, bp_node, 3);
            end
        end
        repeat (60) @(negedge clk);
        check_value($sformatf("send_out[%0d] count while held", bp_node),
                    64'(held_ejects[bp_node]), 64'(depth));
        hold[bp_node] = 1'b0;
        wait_drain();

        check_end_state();
        $display("Errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+logic
logic/noc_pkg.sv
logic/noc_link_if.sv
logic/flit_fifo.sv
logic/output_port.sv
logic/mesh_router.sv
logic/mesh.sv
tests/tb_mesh.sv

// ==== Makefile ====
# Verilator build and run for the 2x2 mesh NoC testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_mesh
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^TEST PASSED$$" $(LOG); then \
		echo "Simulation passed, see $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
